//--- design/colmix_cfg.svh
`ifndef COLMIX_CFG_SVH
`define COLMIX_CFG_SVH

// Palette bank select width, 3 on the usual board and 4 on later ones
`define COLMIX_PALSELW 3

// Pixel strobes from the blanking inputs to the delayed blanking outputs
`define COLMIX_BLANK_DLY 3

// Bit positions inside gfx_en
`define COLMIX_GFX_SCR 0 // Scroll layer enable
`define COLMIX_GFX_OBJ 3 // Object layer enable

`endif

//--- design/colmix_pkg.sv
`include "colmix_cfg.svh"

package colmix_pkg;

    typedef logic [3:0] pxl_t;                       // Layer pixel code, 0 is transparent for objects
    typedef logic [`COLMIX_PALSELW-1:0] pal_sel_t;   // Palette bank
    typedef logic [7:0] pal_addr_t;                  // Palette PROM address
    typedef logic [3:0] color_t;                     // One colour channel
    typedef logic [3:0] gfx_en_t;                    // Per-layer enables

    // Red sits in the upper nibble, as on the board
    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    // Both levels are active low, 0 means blanking
    typedef struct packed {
        logic lhbl;                                  // Horizontal blanking level
        logic lvbl;                                  // Vertical blanking level
    } video_sync_t;

    // Palette download bus shared by the three PROMs
    typedef struct packed {
        pal_addr_t  addr;                            // Entry to write
        color_t     data;                            // Nibble to store
        logic [2:0] we;                              // Write enables for red, green and blue
    } prom_wr_t;

endpackage

//--- design/pal_prom.sv
module pal_prom (
    input  logic                clk,
    input  logic                cen,      // Read register enable, the pixel strobe
    input  colmix_pkg::pal_addr_t wr_addr,
    input  colmix_pkg::color_t  wr_data,
    input  logic                we,       // Write strobe from the download port
    input  colmix_pkg::pal_addr_t rd_addr,
    output colmix_pkg::color_t  q
);

    import colmix_pkg::*;

    localparam int DEPTH = 2 ** $bits(pal_addr_t); // 256 palette entries

    color_t mem [DEPTH];                   // PROM contents survive reset

    // The download port writes on any clock, the strobe does not matter here
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;       // Store the downloaded nibble
        end
    end

    // Registered read, it only moves on a pixel strobe
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];             // Colour for the address registered one strobe earlier
        end
    end

endmodule

//--- design/pixel_prio.sv
`include "colmix_cfg.svh"

module pixel_prio (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  colmix_pkg::pal_sel_t  pal_sel,
    input  colmix_pkg::pxl_t      obj_pxl,
    input  colmix_pkg::pxl_t      scr_pxl,
    input  colmix_pkg::gfx_en_t   gfx_en,
    output colmix_pkg::pal_addr_t pal_addr
);

    import colmix_pkg::*;

    // Address bits left over for the pixel code after the bank select
    localparam int CODEW = $bits(pal_addr_t) - `COLMIX_PALSELW;

    logic                 obj_blank;       // Object layer shows nothing on this pixel
    pxl_t                 scr_gated;       // Scroll pixel after its enable
    logic [$bits(pxl_t):0] code;           // Object wins bit followed by the winning pixel

    always_comb begin
        // An object pixel of 0 is transparent
        obj_blank = (obj_pxl == '0) || !gfx_en[`COLMIX_GFX_OBJ];
        scr_gated = gfx_en[`COLMIX_GFX_SCR] ? scr_pxl : '0; // Disabled scroll falls back to code 0
        if (obj_blank) begin
            code = {1'b0, scr_gated};      // Scroll shows through
        end else begin
            code = {1'b1, obj_pxl};        // Object sits on top
        end
    end

    // With a 4-bit bank select the object wins bit no longer fits and is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            pal_addr <= {pal_sel, code[CODEW-1:0]}; // Bank select on top of the code
        end
    end

endmodule

//--- design/blank_delay.sv
`include "colmix_cfg.svh"

module blank_delay (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  colmix_pkg::video_sync_t sync,
    input  colmix_pkg::rgb_t        rgb_in,
    output colmix_pkg::video_sync_t sync_dly,
    output colmix_pkg::rgb_t        rgb
);

    import colmix_pkg::*;

    localparam int DLY = `COLMIX_BLANK_DLY;

    // The colour reaches this block two strobes behind its pixel, so the
    // mask is taken from the level that is about to enter the last stage
    localparam int MASK_STAGE = DLY - 2;

    video_sync_t dly [DLY];                // Blanking shift register, stage 0 is the newest
    logic        blank;                    // Pixel now leaving the PROMs lies in blanking

    assign blank    = !dly[MASK_STAGE].lhbl || !dly[MASK_STAGE].lvbl;
    assign sync_dly = dly[DLY-1];          // Oldest stage lines up with rgb

    // Resets to blanking so the screen stays dark until the pipe fills
    always_ff @(posedge clk) begin
        if (rst) begin
            dly <= '{default: '0};
        end else if (pxl_cen) begin
            dly[0] <= sync;
            for (int i = 1; i < DLY; i++) begin
                dly[i] <= dly[i-1];        // Advance one stage per strobe
            end
        end
    end

    // Output colour register, black while blanked
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (blank) begin
                rgb <= '0;                 // Force black in the blanking interval
            end else begin
                rgb <= rgb_in;             // Pass the palette colour
            end
        end
    end

endmodule

//--- design/colmix_top.sv
module colmix_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,    // Pixel strobe, the whole pipe steps on it
    input  colmix_pkg::pal_sel_t    pal_sel,    // Palette bank
    input  colmix_pkg::pxl_t        obj_pxl,    // Object layer pixel
    input  colmix_pkg::pxl_t        scr_pxl,    // Scroll layer pixel
    input  colmix_pkg::video_sync_t sync,       // Blanking levels from the sync generator
    input  colmix_pkg::prom_wr_t    prom_wr,    // Palette download bus
    input  colmix_pkg::gfx_en_t     gfx_en,     // Layer enables
    output colmix_pkg::rgb_t        rgb,
    output colmix_pkg::video_sync_t sync_dly
);

    import colmix_pkg::*;

    pal_addr_t pal_addr;                        // Registered palette address
    rgb_t      raw;                             // PROM outputs before blanking

    // Priority stage, strobe n
    pixel_prio u_prio (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pal_sel  (pal_sel),
        .obj_pxl  (obj_pxl),
        .scr_pxl  (scr_pxl),
        .gfx_en   (gfx_en),
        .pal_addr (pal_addr)
    );

    // Palette lookup, strobe n+1
    pal_prom u_red (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_wr.addr),
        .wr_data (prom_wr.data),
        .we      (prom_wr.we[0]),
        .rd_addr (pal_addr),
        .q       (raw.red)
    );

    pal_prom u_green (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_wr.addr),
        .wr_data (prom_wr.data),
        .we      (prom_wr.we[1]),
        .rd_addr (pal_addr),
        .q       (raw.green)
    );

    pal_prom u_blue (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prom_wr.addr),
        .wr_data (prom_wr.data),
        .we      (prom_wr.we[2]),
        .rd_addr (pal_addr),
        .q       (raw.blue)
    );

    // Blanking realignment and blackout, strobe n+2
    blank_delay u_blank (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .sync     (sync),
        .rgb_in   (raw),
        .sync_dly (sync_dly),
        .rgb      (rgb)
    );

endmodule

//--- bench/colmix_properties.sv
`include "colmix_cfg.svh"

module colmix_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    pxl_cen,
    input colmix_pkg::video_sync_t sync,
    input colmix_pkg::video_sync_t sync_dly,
    input colmix_pkg::rgb_t        rgb
);

    timeunit 1ns;
    timeprecision 1ps;

    import colmix_pkg::*;

    video_sync_t hist [`COLMIX_BLANK_DLY];   // Blanking levels seen on the last strobes
    int          fail_count = 0;             // Assertion failures so far

    // History of the blanking inputs with one entry per strobe and blanking after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '{default: '0};
        end else if (pxl_cen) begin
            hist[0] <= sync;
            for (int i = 1; i < `COLMIX_BLANK_DLY; i++) begin
                hist[i] <= hist[i-1];        // Oldest entry is three strobes back
            end
        end
    end

    // Delayed blanking equals the input from three strobes earlier
    a_sync_delay: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> (sync_dly == hist[`COLMIX_BLANK_DLY-1]))
        else begin
            fail_count++;
            $error("sync_dly does not match the blanking input three strobes back");
        end

    // Black whenever either delayed level is in blanking
    a_black_in_blank: assert property (@(posedge clk) disable iff (rst)
        (!sync_dly.lhbl || !sync_dly.lvbl) |-> (rgb == '0))
        else begin
            fail_count++;
            $error("rgb is not black during blanking");
        end

    // Colour holds on clocks without a strobe
    a_rgb_holds: assert property (@(posedge clk) disable iff (rst)
        !pxl_cen |=> $stable(rgb))
        else begin
            fail_count++;
            $error("rgb changed on a clock without a pixel strobe");
        end

endmodule

bind colmix_top colmix_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .pxl_cen  (pxl_cen),
    .sync     (sync),
    .sync_dly (sync_dly),
    .rgb      (rgb)
);

//--- bench/colmix_tb.sv
`include "colmix_cfg.svh"

module colmix_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import colmix_pkg::*;

    localparam int NVEC      = 12;       // Rows in the directed table
    localparam int NRAND     = 200;      // Pixels in the random stream
    localparam int CLK_LIMIT = 8;        // Clocks allowed for each awaited strobe

    // One directed row with the inputs first and the expected results after them
    typedef struct packed {
        pal_sel_t    sel;
        pxl_t        obj;
        pxl_t        scr;
        gfx_en_t     en;
        video_sync_t sync;
        pal_addr_t   addr;               // Expected palette address
        rgb_t        color;              // Expected colour after blanking
    } vector_t;

    // Expected output of one pixel in the random stream
    typedef struct packed {
        rgb_t        color;
        video_sync_t sync;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen = 1'b0;
    pal_sel_t    pal_sel;
    pxl_t        obj_pxl;
    pxl_t        scr_pxl;
    video_sync_t sync;
    prom_wr_t    prom_wr;
    gfx_en_t     gfx_en;
    rgb_t        rgb;
    video_sync_t sync_dly;

    int          rgb_errors;
    int          sync_errors;
    int          addr_errors;
    integer      seed;
    event        abort_ev;              // Raised when a wait runs out of clocks
    expect_t     pending [$];           // Pixels still in flight in the random stream

    // Addresses assume a 3-bit palette bank above the object wins bit and the pixel
    vector_t vectors [NVEC] = '{
        '{3'd3, 4'h5, 4'h9, 4'b1001, 2'b11, 8'h75, 12'h572}, // Object over scroll
        '{3'd3, 4'h0, 4'h9, 4'b1001, 2'b11, 8'h69, 12'h96f}, // Transparent object
        '{3'd5, 4'ha, 4'h3, 4'b0001, 2'b11, 8'ha3, 12'h3a9}, // Object layer disabled
        '{3'd5, 4'ha, 4'h3, 4'b0000, 2'b11, 8'ha0, 12'h0aa}, // Both layers off, code 0
        '{3'd0, 4'hf, 4'h0, 4'b1000, 2'b11, 8'h1f, 12'hf1e}, // Object alone in bank 0
        '{3'd7, 4'h2, 4'hc, 4'b1111, 2'b11, 8'hf2, 12'h2fd},
        '{3'd7, 4'h0, 4'h0, 4'b1111, 2'b11, 8'he0, 12'h0ee}, // Scroll pixel of 0
        '{3'd2, 4'h6, 4'h1, 4'b1001, 2'b01, 8'h56, 12'h000}, // Horizontal blanking
        '{3'd2, 4'h6, 4'h1, 4'b1001, 2'b10, 8'h56, 12'h000}, // Vertical blanking
        '{3'd6, 4'h0, 4'h7, 4'b1001, 2'b11, 8'hc7, 12'h7cb},
        '{3'd1, 4'h9, 4'h4, 4'b0000, 2'b11, 8'h20, 12'h022},
        '{3'd4, 4'h3, 4'h8, 4'b1001, 2'b00, 8'h93, 12'h000}  // Both levels blanking
    };

    colmix_top UUT (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pal_sel  (pal_sel),
        .obj_pxl  (obj_pxl),
        .scr_pxl  (scr_pxl),
        .sync     (sync),
        .prom_wr  (prom_wr),
        .gfx_en   (gfx_en),
        .rgb      (rgb),
        .sync_dly (sync_dly)
    );

    always #4 clk = ~clk;                     // 8 ns pixel clock

    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;                  // Strobe on every second clock
    end

    // Palette contents written by the loader with red from the low nibble and green from the high
    function automatic rgb_t fill_color(input pal_addr_t addr);
        rgb_t c;
        c.red   = addr[3:0];
        c.green = addr[7:4];
        c.blue  = addr[3:0] ^ addr[7:4];      // Blue is the two nibbles mixed
        return c;
    endfunction

    // Palette address from the layer rules
    function automatic pal_addr_t model_addr(input pal_sel_t sel, input pxl_t obj,
                                             input pxl_t scr, input gfx_en_t en);
        logic      obj_wins;
        pxl_t      shown;
        pal_addr_t addr;
        obj_wins = (obj != 4'h0) && en[`COLMIX_GFX_OBJ];
        if (obj_wins) begin
            shown = obj;
        end else begin
            shown = en[`COLMIX_GFX_SCR] ? scr : 4'h0;    // Disabled scroll reads code 0
        end
        addr = pal_addr_t'({obj_wins, shown});
        addr[7 -: `COLMIX_PALSELW] = sel;                // A 4-bit bank covers the wins bit
        return addr;
    endfunction

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            rgb_errors++;
            $display("CHECK FAILED at %0t ns: %s, rgb %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input video_sync_t got, input video_sync_t exp,
                              input string what);
        if (got !== exp) begin
            sync_errors++;
            $display("CHECK FAILED at %0t ns: %s, sync_dly %b expected %b",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input pal_addr_t got, input pal_addr_t exp, input string what);
        if (got !== exp) begin
            addr_errors++;
            $display("CHECK FAILED at %0t ns: %s, pal_addr %h expected %h",
                     $time, what, got, exp);
        end
    endtask

    // Returns on the rising edge of the requested strobe
    task automatic wait_strobes(input int count);
        int seen;
        int clocks;
        seen   = 0;
        clocks = 0;
        while (seen < count) begin
            @(posedge clk);
            clocks++;
            if (pxl_cen) begin
                seen++;
            end else if (clocks > CLK_LIMIT * count) begin
                $display("Timed out after %0d clocks waiting for a pixel strobe", clocks);
                -> abort_ev;
                seen = count;
            end
        end
    endtask

    task automatic drive_pixel(input pal_sel_t sel, input pxl_t obj, input pxl_t scr,
                               input gfx_en_t en, input video_sync_t vs);
        pal_sel <= sel;
        obj_pxl <= obj;
        scr_pxl <= scr;
        gfx_en  <= en;
        sync    <= vs;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Three writes per entry with one per colour PROM while the display is blanked
    task automatic load_palette();
        rgb_t c;
        for (int a = 0; a < 256; a++) begin
            c = fill_color(pal_addr_t'(a));
            @(posedge clk);
            prom_wr <= '{addr: pal_addr_t'(a), data: c.red, we: 3'b001};
            @(posedge clk);
            prom_wr <= '{addr: pal_addr_t'(a), data: c.green, we: 3'b010};
            @(posedge clk);
            prom_wr <= '{addr: pal_addr_t'(a), data: c.blue, we: 3'b100};
        end
        @(posedge clk);
        prom_wr <= '0;
    endtask

    // Output stays dark until the third strobe after reset
    task automatic check_startup();
        @(posedge clk);
        drive_pixel(vectors[0].sel, vectors[0].obj, vectors[0].scr, vectors[0].en, 2'b11);
        apply_reset();
        for (int s = 1; s <= 3; s++) begin
            wait_strobes(1);
            @(negedge clk);
            if (s < 3) begin
                check_rgb(rgb, '0, $sformatf("startup strobe %0d", s));
                check_sync(sync_dly, '0, $sformatf("startup strobe %0d", s));
            end else begin
                check_rgb(rgb, vectors[0].color, "first pixel after reset");
                check_sync(sync_dly, 2'b11, "first pixel after reset");
            end
        end
    endtask

    task automatic run_table();
        foreach (vectors[i]) begin
            wait_strobes(1);
            drive_pixel(vectors[i].sel, vectors[i].obj, vectors[i].scr, vectors[i].en,
                        vectors[i].sync);
            wait_strobes(4);                 // Row held long enough to fill the pipe
            @(negedge clk);
            check_addr(UUT.pal_addr, vectors[i].addr, $sformatf("row %0d", i));
            check_rgb(rgb, vectors[i].color, $sformatf("row %0d", i));
            check_sync(sync_dly, vectors[i].sync, $sformatf("row %0d", i));
        end
    endtask

    // New pixel on every strobe and each one checked once it leaves the pipe
    task automatic run_random();
        pal_sel_t    sel;
        pxl_t        obj;
        pxl_t        scr;
        gfx_en_t     en;
        video_sync_t vs;
        logic [31:0] r;
        expect_t     exp;
        expect_t     due;
        pending.delete();
        for (int i = 0; i < NRAND; i++) begin
            wait_strobes(1);
            r   = $random(seed);
            sel = r[`COLMIX_PALSELW-1:0];
            obj = r[7:4];
            scr = r[11:8];
            en  = r[15:12];
            vs.lhbl = |r[17:16];             // Each level blanks on about a quarter
            vs.lvbl = |r[19:18];
            drive_pixel(sel, obj, scr, en, vs);
            exp.sync  = vs;
            exp.color = (vs.lhbl && vs.lvbl) ? fill_color(model_addr(sel, obj, scr, en)) : '0;
            pending.push_back(exp);
            @(negedge clk);
            if (pending.size() > 3) begin
                due = pending.pop_front();   // Pixel driven three strobes back
                check_rgb(rgb, due.color, $sformatf("random pixel %0d", i - 3));
                check_sync(sync_dly, due.sync, $sformatf("random pixel %0d", i - 3));
                @(negedge clk);              // One clock on and still before the next strobe
                check_rgb(rgb, due.color, $sformatf("random pixel %0d held", i - 3));
            end
        end
    endtask

    initial begin
        @(abort_ev);
        $display("test failed");
        $finish;
    end

    initial begin
        rgb_errors  = 0;
        sync_errors = 0;
        addr_errors = 0;
        seed        = 15011;
        rst     <= 1'b1;
        prom_wr <= '0;
        drive_pixel('0, '0, '0, '0, '0);     // Blanked while the palette loads
        apply_reset();
        load_palette();
        check_startup();
        run_table();
        run_random();
        $display("errors: rgb %0d, sync %0d, addr %0d, assertions %0d",
                 rgb_errors, sync_errors, addr_errors, UUT.u_props.fail_count);
        if (rgb_errors + sync_errors + addr_errors + UUT.u_props.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/colmix_pkg.sv
design/pal_prom.sv
design/pixel_prio.sv
design/blank_delay.sv
design/colmix_top.sv
bench/colmix_properties.sv
bench/colmix_tb.sv
